//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= cpu_tb
RTL_TOP    ?= cpu_top
FILELIST   ?= list.f
PASS_MSG   ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire [7:0]            a,        // first input
    input  wire [7:0]            b,        // second input, mov passes it
    input  wire cpu_pkg::alu_op_e op,
    input  wire                  we_flags,
    output logic [7:0]           result,
    output cpu_pkg::flags_t      flags
);
    import cpu_pkg::*;

    logic [8:0] sum;   // bit 8 is carry out or borrow
    logic       c_new;
    logic       v_new;
    flags_t     flags_d;

    always_comb begin
        sum   = 9'h000;
        c_new = 1'b0; // logic ops and pass clear c and v
        v_new = 1'b0;
        case (op)
            ALU_ADD, ALU_ADC: begin
                sum   = {1'b0, a} + {1'b0, b} + {8'h00, (op == ALU_ADC) & flags.c};
                c_new = sum[8];
                v_new = (a[7] == b[7]) && (sum[7] != a[7]);
            end
            ALU_SUB, ALU_SBB: begin
                sum   = {1'b0, a} - {1'b0, b} - {8'h00, (op == ALU_SBB) & flags.c};
                c_new = sum[8]; // borrow
                v_new = (a[7] != b[7]) && (sum[7] != a[7]);
            end
            ALU_AND: sum = {1'b0, a & b};
            ALU_OR:  sum = {1'b0, a | b};
            ALU_XOR: sum = {1'b0, a ^ b};
            ALU_SHL: begin
                sum   = {1'b0, a[6:0], 1'b0};
                c_new = a[7]; // bit shifted out
            end
            ALU_SHR: begin
                sum   = {2'b00, a[7:1]};
                c_new = a[0];
            end
            ALU_INC: begin
                sum   = {1'b0, a} + 9'd1;
                c_new = sum[8];
                v_new = a == 8'h7f; // 127 -> -128
            end
            ALU_DEC: begin
                sum   = {1'b0, a} - 9'd1;
                c_new = sum[8];
                v_new = a == 8'h80;
            end
            default: sum = {1'b0, b}; // mov and the spare codes
        endcase
    end

    assign result  = sum[7:0];
    assign flags_d = '{v: v_new, n: result[7], c: c_new, z: result == 8'h00};

    // flag register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (we_flags) begin
            flags <= flags_d;
        end
    end

    // mov and non-ALU cycles leave the flags for a later jc
    a_flags_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !we_flags |=> $stable(flags));

endmodule

`default_nettype wire

//--- control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire              clk,
    input  wire              arst_n,
    input  wire [7:0]        mem_rdata, // instruction byte on fetch
    input  wire cpu_pkg::flags_t flags,  // stored ALU flags
    output logic [7:0]       ir,
    output cpu_pkg::ctrl_t   ctrl
);
    import cpu_pkg::*;

    logic      cycle;      // 0 fetch, 1 execute
    logic      supercycle; // second pair of an LDI
    op_class_e cls;
    logic      flag_set;   // flag picked by ir[1:0]
    logic      cond;       // jc taken
    logic      load_d;     // write register d this cycle
    logic      alu_flags;  // every ALU op but mov

    // cycle toggles every clock, supercycle only across an LDI
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle      <= 1'b0;
            supercycle <= 1'b0;
        end else begin
            cycle <= ~cycle;
            if (cycle && cls == OP_LDI) begin
                supercycle <= ~supercycle; // end of each LDI pair
            end
        end
    end

    // instruction register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= 8'h00;
        end else if (ctrl.we_ir) begin
            ir <= mem_rdata;
        end
    end

    assign cls = decode_class(ir);

    always_comb begin
        case (ir[1:0])
            FLAG_Z:  flag_set = flags.z;
            FLAG_C:  flag_set = flags.c;
            FLAG_N:  flag_set = flags.n;
            FLAG_V:  flag_set = flags.v;
            default: flag_set = 1'b0;
        endcase
    end

    assign cond      = flag_set ^ ir[2]; // ir[2] inverts the test
    assign alu_flags = ir[6:3] != ALU_MOV;

    always_comb begin
        ctrl   = '0;
        load_d = 1'b0;
        if (!cycle) begin
            if (!supercycle) begin
                ctrl.we_ir = 1'b1; // plain fetch
            end else if (cls == OP_LDI) begin
                ctrl.di_sel = DI_MEM; // immediate byte at IP
                load_d      = 1'b1;
            end
        end else begin
            ctrl.inc_ip = 1'b1; // every execute cycle
            case (cls)
                OP_LD: begin
                    ctrl.addr_dp = 1'b1;
                    ctrl.di_sel  = DI_MEM;
                    load_d       = 1'b1;
                end
                OP_ST: begin
                    ctrl.addr_dp = 1'b1;
                    ctrl.mem_we  = 1'b1;
                    ctrl.st_sel  = ir[0];
                end
                OP_ALU0: begin
                    ctrl.di_sel   = DI_ALU;
                    ctrl.we_a     = 1'b1; // result always to A
                    ctrl.we_flags = alu_flags;
                end
                OP_ALU1: begin
                    ctrl.di_sel   = DI_ALU;
                    ctrl.alu_rev  = 1'b1;
                    load_d        = 1'b1;
                    ctrl.we_flags = alu_flags;
                end
                OP_JC: begin
                    ctrl.swap_p = cond;
                end
                OP_JMP: begin
                    ctrl.swap_p = 1'b1;
                end
                default: begin
                    // LDI pairs and illegal ops only step IP
                end
            endcase
        end

        // register d write strobe
        if (load_d) begin
            case (reg_sel_e'(ir[1:0]))
                REG_A:   ctrl.we_a  = 1'b1;
                REG_B:   ctrl.we_b  = 1'b1;
                REG_PL:  ctrl.we_pl = 1'b1;
                REG_PH:  ctrl.we_ph = 1'b1;
                default: ctrl.we_a  = 1'b0;
            endcase
        end
    end

    // stores only ever go out on the data pointer
    a_st_addr: assert property (@(posedge clk) disable iff (!arst_n)
        ctrl.mem_we |-> ctrl.addr_dp);

    // jumps resolve in execute only
    a_swap_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        ctrl.swap_p |-> cycle);

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // top nibble of ir, ALU forms have ir[7] low
    localparam logic [3:0] OPC_LD  = 4'b1000; // 1000__dd
    localparam logic [3:0] OPC_ST  = 4'b1001; // 1001___s
    localparam logic [3:0] OPC_LDI = 4'b1010; // 1010__dd
    localparam logic [3:0] OPC_JMP = 4'b1100; // 11000cff jc, 11001___ jmp

    typedef enum logic [2:0] {
        OP_ALU0,    // A = op(A, d)
        OP_ALU1,    // d = op(d, A)
        OP_LD,
        OP_ST,
        OP_LDI,
        OP_JC,
        OP_JMP,
        OP_ILLEGAL  // just steps IP
    } op_class_e;

    // ir[6:3]
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_ADC = 4'b0001,
        ALU_SUB = 4'b0010,
        ALU_SBB = 4'b0011, // borrow in from c
        ALU_AND = 4'b0100,
        ALU_OR  = 4'b0101,
        ALU_XOR = 4'b0110,
        ALU_SHL = 4'b0111,
        ALU_MOV = 4'b1000, // flags untouched
        ALU_SHR = 4'b1010,
        ALU_INC = 4'b1011,
        ALU_DEC = 4'b1100
    } alu_op_e;

    // flag index in ir[1:0] for jc
    localparam logic [1:0] FLAG_Z = 2'd0;
    localparam logic [1:0] FLAG_C = 2'd1;
    localparam logic [1:0] FLAG_N = 2'd2;
    localparam logic [1:0] FLAG_V = 2'd3;

    // declared high to low so that bit 0 is z
    typedef struct packed {
        logic v;
        logic n;
        logic c; // carry out, or borrow on subtract
        logic z;
    } flags_t;

    typedef enum logic [1:0] {
        REG_A  = 2'd0,
        REG_B  = 2'd1,
        REG_PL = 2'd2, // DP low byte
        REG_PH = 2'd3  // DP high byte
    } reg_sel_e;

    // internal data bus source
    typedef enum logic [1:0] {
        DI_NONE = 2'b00,
        DI_MEM  = 2'b01,
        DI_ALU  = 2'b10
    } di_sel_e;

    typedef struct packed {
        logic    we_ir;    // latch IR at end of fetch
        logic    inc_ip;
        logic    swap_p;   // exchange IP and DP
        logic    addr_dp;  // address from DP instead of IP
        logic    we_a;
        logic    we_b;
        logic    we_pl;
        logic    we_ph;
        di_sel_e di_sel;
        logic    we_flags;
        logic    alu_rev;  // ALU1 form, reg[d] is the first ALU input
        logic    st_sel;   // 0 stores A, 1 stores B
        logic    mem_we;
    } ctrl_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        we;
    } mem_req_t;

    // instruction class from the latched ir
    function automatic op_class_e decode_class(input logic [7:0] ir);
        op_class_e cls;
        if (!ir[7]) begin
            cls = ir[2] ? OP_ALU1 : OP_ALU0;
        end else begin
            case (ir[7:4])
                OPC_LD:  cls = OP_LD;
                OPC_ST:  cls = OP_ST;
                OPC_LDI: cls = OP_LDI;
                OPC_JMP: cls = ir[3] ? OP_JMP : OP_JC;
                default: cls = OP_ILLEGAL;
            endcase
        end
        return cls;
    endfunction

endpackage

`default_nettype wire

//--- cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int NT = 18;        // table entries
    localparam int PERIOD = 40;

    logic       clk;
    logic       arst_n;
    logic [7:0] mem_rdata;
    mem_req_t   mem_bus;

    logic [7:0] memory [0:65535];  // 64 KiB, combinational read

    // stimulus and expected stores, one row per test
    string       t_name  [NT];
    logic [7:0]  t_prog  [NT][16];
    int          t_len   [NT];
    int          t_cycles[NT];     // exact cycles, fetch included
    logic [15:0] t_paddr [NT];     // one preloaded byte
    logic [7:0]  t_pdata [NT];
    int          t_nexp  [NT];
    logic [23:0] t_exp   [NT][4];  // {addr, data}

    logic [23:0] seen[$];          // stores seen on the port
    int          errors = 0;
    int          checks = 0;
    int          limit_cycles = 0; // watchdog, 0 until the table is built

    cpu_top #(
        .reset_vector (16'h0000)
    ) cpu_top_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_rdata (mem_rdata),
        .mem       (mem_bus)
    );

    assign mem_rdata = memory[mem_bus.addr];

    always @(posedge clk) begin
        if (mem_bus.we) memory[mem_bus.addr] <= mem_bus.wdata;
    end

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // bytes come left aligned, first byte in the top bits
    task automatic define_test(input int i, input string name, input int len,
                               input int cycles, input logic [127:0] prog);
        t_name[i]   = name;
        t_len[i]    = len;
        t_cycles[i] = cycles;
        t_nexp[i]   = 0;
        t_paddr[i]  = 16'hffff; // out of the way unless a test sets it
        t_pdata[i]  = 8'($urandom);
        for (int k = 0; k < 16; k++) begin
            t_prog[i][k] = prog[127 - 8 * k -: 8];
        end
    endtask

    task automatic expect_store(input int i, input logic [15:0] addr, input logic [7:0] data);
        t_exp[i][t_nexp[i]] = {addr, data};
        t_nexp[i]++;
    endtask

    // flags from one ALU0 op on B, then jc, then ST A or ST B
    task automatic add_jc(input int i, input string name, input logic [7:0] x,
                          input logic [7:0] y, input logic [7:0] op, input logic [7:0] res,
                          input logic inv, input logic [1:0] f, input logic taken);
        define_test(i, name, 10, 18, {8'hA2, 8'h09, 8'hA0, x, 8'hA1, y, op,
                    {5'b11000, inv, f}, 8'h90, 8'h91, 48'h0});
        if (taken) expect_store(i, 16'h0008, y); // ST B through the return address
        else       expect_store(i, 16'h0009, res);
    endtask

    task automatic build_table();
        logic [7:0] ra;
        logic [7:0] rb;
        logic [7:0] rl;
        logic [7:0] rh;
        logic [7:0] rx;
        ra = 8'($urandom);
        rb = 8'($urandom);
        rl = 8'($urandom);
        rh = 8'($urandom) | 8'h80; // keeps DP clear of the program
        rx = 8'($urandom);
        define_test(0, "ldi_st", 10, 20, {8'hA0, ra, 8'hA1, rb, 8'hA2, rl, 8'hA3, rh,
                    8'h90, 8'h91, 48'h0});
        expect_store(0, {rh, rl}, ra);
        expect_store(0, {rh, rl}, rb);
        // f0+20 sets c, then 01+20+c
        define_test(1, "add_adc", 14, 28, {64'hA2_00_A3_20_A0_F0_A1_20,
                    48'h01_90_A0_01_09_90, 16'h0});
        expect_store(1, 16'h2000, 8'h10);
        expect_store(1, 16'h2000, 8'h22);
        // 10-30 borrows, then e0-30-1, then xor
        define_test(2, "sub_sbb_xor", 14, 28, {64'hA2_10_A3_20_A0_10_A1_30,
                    48'h11_90_19_90_31_90, 16'h0});
        expect_store(2, 16'h2010, 8'hE0);
        expect_store(2, 16'h2010, 8'hAF);
        expect_store(2, 16'h2010, 8'h9F);
        define_test(3, "and_or_shift", 15, 30, {64'hA2_00_A3_21_A0_C3_A1_5A,
                    56'h21_29_90_39_90_51_90, 8'h0});
        expect_store(3, 16'h2100, 8'h5A);
        expect_store(3, 16'h2100, 8'hB4);
        expect_store(3, 16'h2100, 8'h5A);
        // ALU1 on B: inc, dec, then mov copies A
        define_test(4, "alu1_inc_dec_mov", 14, 28, {64'hA2_00_A3_22_A0_05_A1_7F,
                    48'h5D_91_65_91_45_91, 16'h0});
        expect_store(4, 16'h2200, 8'h80);
        expect_store(4, 16'h2200, 8'h7F);
        expect_store(4, 16'h2200, 8'h05);
        // PL += A, then PH -= A
        define_test(5, "alu1_pointer", 10, 20, {80'hA2_10_A3_23_A0_05_06_90_17_90, 48'h0});
        expect_store(5, 16'h2315, 8'h05);
        expect_store(5, 16'h1E15, 8'h05);
        add_jc(6,  "jc_z_set",   8'h05, 8'h05, 8'h11, 8'h00, 1'b0, 2'd0, 1'b1);
        add_jc(7,  "jc_z_clear", 8'h05, 8'h05, 8'h11, 8'h00, 1'b1, 2'd0, 1'b0);
        add_jc(8,  "jc_c_set",   8'hF0, 8'h20, 8'h01, 8'h10, 1'b0, 2'd1, 1'b1);
        add_jc(9,  "jc_c_clear", 8'hF0, 8'h20, 8'h01, 8'h10, 1'b1, 2'd1, 1'b0);
        add_jc(10, "jc_n_set",   8'h10, 8'h90, 8'h01, 8'hA0, 1'b0, 2'd2, 1'b1);
        add_jc(11, "jc_n_clear", 8'h10, 8'h90, 8'h01, 8'hA0, 1'b1, 2'd2, 1'b0);
        add_jc(12, "jc_v_set",   8'h70, 8'h10, 8'h01, 8'h80, 1'b0, 2'd3, 1'b1);
        add_jc(13, "jc_v_clear", 8'h70, 8'h10, 8'h01, 8'h80, 1'b1, 2'd3, 1'b0);
        // sub gives z, mov A,B in between must keep it
        define_test(14, "mov_keeps_z", 11, 20, {88'hA2_0A_A0_05_A1_05_11_41_C0_90_91, 40'h0});
        expect_store(14, 16'h0009, 8'h05);
        // spare op 1001 copies B like mov but clears z, so jc falls through
        define_test(15, "spare_writes_flags", 11, 20,
                    {88'hA2_0A_A0_05_A1_05_11_49_C0_90_91, 40'h0});
        expect_store(15, 16'h000A, 8'h05);
        // jmp to 6, ST A lands at old IP+1
        define_test(16, "jmp_return", 7, 12, {8'hA2, 8'h06, 8'hA0, rx, 8'hC8, 8'h00,
                    8'h90, 72'h0});
        expect_store(16, 16'h0005, rx);
        define_test(17, "ld_st", 8, 16, {64'hA2_56_A3_34_80_A2_78_90, 64'h0});
        t_paddr[17] = 16'h3456; // LD source
        expect_store(17, 16'h3478, t_pdata[17]);
    endtask

    task automatic run_test(input int i);
        @(posedge clk);
        arst_n <= 1'b0;
        for (int a = 0; a < 65536; a++) begin
            memory[a] <= 8'($urandom); // unused bytes random
        end
        for (int k = 0; k < t_len[i]; k++) begin
            memory[k] <= t_prog[i][k];
        end
        memory[t_paddr[i]] <= t_pdata[i];
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        seen.delete();
        repeat (t_cycles[i]) begin
            @(posedge clk);
            if (mem_bus.we) seen.push_back({mem_bus.addr, mem_bus.wdata});
        end
        for (int j = 0; j < t_nexp[i] || j < seen.size(); j++) begin
            if (j >= seen.size()) begin
                $display("test %s: expected store %0d never happened", t_name[i], j);
                errors++;
            end else if (j >= t_nexp[i]) begin
                $display("test %s: unexpected extra store %h", t_name[i], seen[j]);
                errors++;
            end else begin
                check_value(t_name[i], t_exp[i][j], seen[j]);
            end
        end
    endtask

    task automatic check_value(input string test, input logic [23:0] expected,
                               input logic [23:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", test, expected, actual);
            errors++;
        end
    endtask

    initial begin
        int total;
        arst_n = 1'b0;
        void'($urandom(32'hd85e370e));
        build_table();
        total = 200; // margin
        for (int i = 0; i < NT; i++) total += t_cycles[i] + 8;
        limit_cycles = total;
        for (int i = 0; i < NT; i++) run_test(i);
        $display("tests %0d, stores checked %0d, errors %0d", NT, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter logic [15:0] reset_vector = 16'h0000 // first fetch address
) (
    input  wire               clk,
    input  wire               arst_n,
    input  wire [7:0]         mem_rdata,
    output cpu_pkg::mem_req_t mem
);
    import cpu_pkg::*;

    ctrl_t       ctrl;
    flags_t      flags;
    logic [7:0]  ir;
    logic [7:0]  di;         // internal data bus
    logic [7:0]  alu_a;
    logic [7:0]  alu_b;
    logic [7:0]  alu_result;
    logic [7:0]  pl;
    logic [7:0]  ph;
    logic [7:0]  wdata;
    logic [15:0] addr;

    control_unit control_unit_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_rdata (mem_rdata),
        .flags     (flags),
        .ir        (ir),
        .ctrl      (ctrl)
    );

    alu alu_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .a        (alu_a),
        .b        (alu_b),
        .op       (alu_op_e'(ir[6:3])),
        .we_flags (ctrl.we_flags),
        .result   (alu_result),
        .flags    (flags)
    );

    register_file register_file_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl),
        .sel        (reg_sel_e'(ir[1:0])),
        .mem_rdata  (mem_rdata),
        .alu_result (alu_result),
        .pl         (pl),
        .ph         (ph),
        .di         (di),
        .a          (alu_a),
        .operand    (alu_b),
        .wdata      (wdata)
    );

    pointer_unit #(
        .reset_vector (reset_vector)
    ) pointer_unit_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .ctrl   (ctrl),
        .di     (di),
        .addr   (addr),
        .pl     (pl),
        .ph     (ph)
    );

    assign mem = '{addr: addr, wdata: wdata, we: ctrl.mem_we};
endmodule

`default_nettype wire

//--- list.f
cpu_pkg.sv
control_unit.sv
alu.sv
register_file.sv
pointer_unit.sv
cpu_top.sv
cpu_tb.sv

//--- pointer_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pointer_unit #(
    parameter logic [15:0] reset_vector = 16'h0000
) (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire cpu_pkg::ctrl_t ctrl,
    input  wire [7:0]           di,    // source for PL and PH writes
    output logic [15:0]         addr,
    output logic [7:0]          pl,
    output logic [7:0]          ph
);
    logic [15:0] ip;
    logic [15:0] dp;
    logic [15:0] ip_inc; // IP after the execute step

    assign ip_inc = ctrl.inc_ip ? ip + 16'd1 : ip;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ip <= reset_vector;
            dp <= 16'h0000;
        end else if (ctrl.swap_p) begin
            // increment first, then exchange
            ip <= dp;
            dp <= ip_inc; // return address
        end else begin
            ip <= ip_inc;
            if (ctrl.we_pl) dp[7:0]  <= di;
            if (ctrl.we_ph) dp[15:8] <= di;
        end
    end

    assign addr = ctrl.addr_dp ? dp : ip; // DP only for LD and ST
    assign pl   = dp[7:0];
    assign ph   = dp[15:8];

    // a byte write during a jump would be lost to the swap
    a_swap_wr: assert property (@(posedge clk) disable iff (!arst_n)
        !(ctrl.swap_p && (ctrl.we_pl || ctrl.we_ph)));

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire cpu_pkg::ctrl_t   ctrl,
    input  wire cpu_pkg::reg_sel_e sel,      // ir[1:0]
    input  wire [7:0]             mem_rdata,
    input  wire [7:0]             alu_result,
    input  wire [7:0]             pl,        // DP bytes from pointer_unit
    input  wire [7:0]             ph,
    output logic [7:0]            di,        // internal data bus
    output logic [7:0]            a,         // ALU first input
    output logic [7:0]            operand,   // ALU second input
    output logic [7:0]            wdata
);
    import cpu_pkg::*;

    logic [7:0] a_q;
    logic [7:0] b_q;
    logic [7:0] reg_d; // register picked by sel

    always_comb begin
        case (ctrl.di_sel)
            DI_MEM:  di = mem_rdata;
            DI_ALU:  di = alu_result;
            default: di = 8'h00; // bus idle
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_q <= 8'h00;
            b_q <= 8'h00;
        end else begin
            if (ctrl.we_a) a_q <= di;
            if (ctrl.we_b) b_q <= di;
        end
    end

    always_comb begin
        case (sel)
            REG_A:   reg_d = a_q;
            REG_B:   reg_d = b_q;
            REG_PL:  reg_d = pl;
            REG_PH:  reg_d = ph;
            default: reg_d = 8'h00;
        endcase
    end

    // ALU1 form computes op(reg[d], A), so the inputs trade places
    assign a       = ctrl.alu_rev ? reg_d : a_q;
    assign operand = ctrl.alu_rev ? a_q : reg_d;

    assign wdata = ctrl.st_sel ? b_q : a_q; // ir[0] of ST
endmodule

`default_nettype wire
